// File: design/panel_pkg.sv
package panel_pkg;

    // top-level instrument selection
    typedef enum logic [1:0] {
        MODE_MENU   = 2'd0,
        MODE_SIGGEN = 2'd1,
        MODE_SCOPE  = 2'd2,
        MODE_LA     = 2'd3
    } mode_e;

    // bit positions within key_in
    localparam int NUM_KEYS    = 7;
    localparam int KEY_LEFT    = 0;
    localparam int KEY_RIGHT   = 1;
    localparam int KEY_UP      = 2;
    localparam int KEY_DOWN    = 3;
    localparam int KEY_CONFIRM = 4;
    localparam int KEY_QUIT    = 5;
    localparam int KEY_CAPTURE = 6;

    // about 20 us of stable level at 50 MHz
    localparam int DEBOUNCE_CYCLES = 1000;
    localparam int DEBOUNCE_W      = $clog2(DEBOUNCE_CYCLES);

    // menu cursor 0 siggen, 1 scope, 2 logic analyzer
    localparam logic [1:0] MENU_LAST = 2'd2;

    // rows 0..3 are fields, row 4 is run
    localparam logic [2:0] SG_RUN_ROW   = 3'd4;
    localparam logic [1:0] SG_FIELD_MAX = 2'd3;

    localparam logic [1:0] ZOOM_MAX = 2'd2;

    // marker x position in display pixels
    localparam logic [11:0] MARKER_MIN  = 12'd80;
    localparam logic [11:0] MARKER_MAX  = 12'd1440;
    localparam logic [11:0] MARKER_STEP = 12'd80;

    localparam logic [3:0] DIV_MAX   = 4'd13;
    localparam logic [3:0] DIV_RESET = 4'd10;

endpackage

// File: design/panel_keys_if.sv
`timescale 1ns/100ps

// one-cycle key release events
interface panel_keys_if;

    logic left;
    logic right;
    logic up;
    logic down;
    logic confirm;
    logic quit;
    logic capture;

    modport src (
        output left, right, up, down, confirm, quit, capture
    );

    modport dst (
        input left, right, up, down, confirm, quit, capture
    );

endinterface

// File: design/key_debounce.sv
`timescale 1ns/100ps

module key_debounce
    import panel_pkg::*;
(
    input  logic clk_50M,
    input  logic rst_n,
    input  logic key,
    output logic release_pulse
);

    logic [1:0]            sync;
    logic                  level;
    logic [DEBOUNCE_W-1:0] cnt;

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            sync          <= 2'b00;
            level         <= 1'b0;
            cnt           <= '0;
            release_pulse <= 1'b0;
        end else begin
            sync          <= {sync[0], key};
            release_pulse <= 1'b0;
            // restart whenever the input agrees with the accepted level
            if (sync[1] == level) begin
                cnt <= '0;
            end else if (cnt == DEBOUNCE_W'(DEBOUNCE_CYCLES - 1)) begin
                level         <= sync[1];
                cnt           <= '0;
                // falling edge of the accepted level
                release_pulse <= level;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// File: design/mode_menu.sv
`timescale 1ns/100ps

module mode_menu
    import panel_pkg::*;
(
    input  logic              clk_50M,
    input  logic              rst_n,
    panel_keys_if.dst         keys,
    output mode_e             mode,
    output logic [1:0]        menu_cursor
);

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            mode        <= MODE_MENU;
            menu_cursor <= 2'd0;
        end else begin
            case (mode)
                MODE_MENU: begin
                    if (keys.confirm) begin
                        // cursor 0..2 maps onto siggen..la
                        mode <= mode_e'(menu_cursor + 2'd1);
                    end else if (keys.left) begin
                        if (menu_cursor == 2'd0) begin
                            menu_cursor <= MENU_LAST;
                        end else begin
                            menu_cursor <= menu_cursor - 2'd1;
                        end
                    end else if (keys.right) begin
                        if (menu_cursor == MENU_LAST) begin
                            menu_cursor <= 2'd0;
                        end else begin
                            menu_cursor <= menu_cursor + 2'd1;
                        end
                    end
                end
                MODE_SIGGEN,
                MODE_SCOPE,
                MODE_LA: begin
                    if (keys.quit) begin
                        mode        <= MODE_MENU;
                        menu_cursor <= 2'd0;
                    end
                end
            endcase
        end
    end

endmodule

// File: design/siggen_settings.sv
`timescale 1ns/100ps

module siggen_settings
    import panel_pkg::*;
(
    input  logic       clk_50M,
    input  logic       rst_n,
    panel_keys_if.dst  keys,
    input  mode_e      mode,
    output logic [2:0] sg_row,
    output logic [1:0] sg_wave,
    output logic [1:0] sg_amp,
    output logic [1:0] sg_freq,
    output logic [1:0] sg_phase_duty,
    output logic       sg_run
);

    // wave, amplitude, frequency, phase/duty
    logic [1:0] field [0:SG_RUN_ROW-1];
    logic [1:0] row_idx;

    assign row_idx = sg_row[1:0];

    // row cursor
    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            sg_row <= 3'd0;
        end else if (mode != MODE_SIGGEN) begin
            sg_row <= 3'd0;
        end else if (keys.up) begin
            if (sg_row == 3'd0) begin
                sg_row <= SG_RUN_ROW;
            end else begin
                sg_row <= sg_row - 3'd1;
            end
        end else if (keys.down) begin
            if (sg_row == SG_RUN_ROW) begin
                sg_row <= 3'd0;
            end else begin
                sg_row <= sg_row + 3'd1;
            end
        end
    end

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            field  <= '{default: 2'd0};
            sg_run <= 1'b0;
        end else if (mode != MODE_SIGGEN) begin
            field  <= '{default: 2'd0};
            sg_run <= 1'b0;
        end else if (sg_row < SG_RUN_ROW) begin
            if (keys.left) begin
                if (field[row_idx] == 2'd0) begin
                    field[row_idx] <= SG_FIELD_MAX;
                end else begin
                    field[row_idx] <= field[row_idx] - 2'd1;
                end
            end else if (keys.right) begin
                if (field[row_idx] == SG_FIELD_MAX) begin
                    field[row_idx] <= 2'd0;
                end else begin
                    field[row_idx] <= field[row_idx] + 2'd1;
                end
            end
        end else if (keys.confirm) begin
            // run stays on until the generator is left
            sg_run <= 1'b1;
        end
    end

    assign sg_wave       = field[0];
    assign sg_amp        = field[1];
    assign sg_freq       = field[2];
    assign sg_phase_duty = field[3];

endmodule

// File: design/scope_settings.sv
`timescale 1ns/100ps

module scope_settings
    import panel_pkg::*;
(
    input  logic       clk_50M,
    input  logic       rst_n,
    panel_keys_if.dst  keys,
    input  mode_e      mode,
    output logic       scope_fft,
    output logic [1:0] scope_vzoom,
    output logic [1:0] scope_hzoom
);

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            scope_fft <= 1'b0;
        end else if (mode != MODE_SCOPE) begin
            scope_fft <= 1'b0;
        end else if (keys.confirm) begin
            scope_fft <= 1'b1;
        end
    end

    // zoom only applies to the time-domain view
    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            scope_vzoom <= 2'd0;
            scope_hzoom <= 2'd0;
        end else if (mode != MODE_SCOPE || scope_fft || keys.confirm) begin
            scope_vzoom <= 2'd0;
            scope_hzoom <= 2'd0;
        end else begin
            if (keys.up) begin
                scope_vzoom <= (scope_vzoom == ZOOM_MAX) ? 2'd0 : scope_vzoom + 2'd1;
            end else if (keys.down) begin
                scope_vzoom <= (scope_vzoom == 2'd0) ? ZOOM_MAX : scope_vzoom - 2'd1;
            end
            if (keys.right) begin
                scope_hzoom <= (scope_hzoom == ZOOM_MAX) ? 2'd0 : scope_hzoom + 2'd1;
            end else if (keys.left) begin
                scope_hzoom <= (scope_hzoom == 2'd0) ? ZOOM_MAX : scope_hzoom - 2'd1;
            end
        end
    end

endmodule

// File: design/la_settings.sv
`timescale 1ns/100ps

module la_settings
    import panel_pkg::*;
(
    input  logic        clk_50M,
    input  logic        rst_n,
    panel_keys_if.dst   keys,
    input  mode_e       mode,
    input  logic [1:0]  menu_cursor,
    output logic        la_pause,
    output logic        la_pan_left,
    output logic        la_pan_right,
    output logic        la_trig_mode,
    output logic        la_capture,
    output logic [11:0] la_marker_x,
    output logic [3:0]  la_div_sel
);

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            la_pause     <= 1'b0;
            la_pan_left  <= 1'b0;
            la_pan_right <= 1'b0;
            la_trig_mode <= 1'b1;
            la_capture   <= 1'b0;
            la_marker_x  <= MARKER_MIN;
            la_div_sel   <= DIV_RESET;
        end else if (mode == MODE_LA) begin
            if (keys.confirm) begin
                la_pause <= ~la_pause;
            end
            // pan only while the display is frozen
            la_pan_left  <= la_pause & keys.up;
            la_pan_right <= la_pause & keys.down;
            if (keys.left) begin
                if (la_marker_x == MARKER_MIN) begin
                    la_marker_x <= MARKER_MAX;
                end else begin
                    la_marker_x <= la_marker_x - MARKER_STEP;
                end
            end else if (keys.right) begin
                if (la_marker_x == MARKER_MAX) begin
                    la_marker_x <= MARKER_MIN;
                end else begin
                    la_marker_x <= la_marker_x + MARKER_STEP;
                end
            end
            if (!la_pause) begin
                if (keys.up) begin
                    la_div_sel <= (la_div_sel == DIV_MAX) ? 4'd0 : la_div_sel + 4'd1;
                end else if (keys.down) begin
                    la_div_sel <= (la_div_sel == 4'd0) ? DIV_MAX : la_div_sel - 4'd1;
                end
            end
            if (keys.capture) begin
                la_capture <= 1'b1;
            end
        end else begin
            la_pause     <= 1'b0;
            la_pan_left  <= 1'b0;
            la_pan_right <= 1'b0;
            la_capture   <= 1'b0;
            la_marker_x  <= MARKER_MIN;
            la_div_sel   <= DIV_RESET;
            // trigger mode is picked on the menu page before entering
            if (mode == MODE_MENU && menu_cursor == MENU_LAST) begin
                if (keys.up) begin
                    la_trig_mode <= 1'b1;
                end else if (keys.down) begin
                    la_trig_mode <= 1'b0;
                end
            end else begin
                la_trig_mode <= 1'b1;
            end
        end
    end

endmodule

// File: design/panel_top.sv
`timescale 1ns/100ps

module panel_top
    import panel_pkg::*;
(
    input  logic                clk_50M,
    input  logic                rst_n,
    input  logic [NUM_KEYS-1:0] key_in,
    output logic [1:0]          mode,
    output logic [1:0]          menu_cursor,
    output logic [2:0]          sg_row,
    output logic [1:0]          sg_wave,
    output logic [1:0]          sg_amp,
    output logic [1:0]          sg_freq,
    output logic [1:0]          sg_phase_duty,
    output logic                sg_run,
    output logic                scope_fft,
    output logic [1:0]          scope_vzoom,
    output logic [1:0]          scope_hzoom,
    output logic                la_pause,
    output logic                la_pan_left,
    output logic                la_pan_right,
    output logic                la_trig_mode,
    output logic                la_capture,
    output logic [11:0]         la_marker_x,
    output logic [3:0]          la_div_sel
);

    logic [NUM_KEYS-1:0] key_rel;
    mode_e               mode_q;

    panel_keys_if keys ();

    for (genvar i = 0; i < NUM_KEYS; i++) begin : g_key
        key_debounce u_key_debounce (
            .clk_50M       (clk_50M),
            .rst_n         (rst_n),
            .key           (key_in[i]),
            .release_pulse (key_rel[i])
        );
    end

    // release events onto the shared key bus
    assign keys.left    = key_rel[KEY_LEFT];
    assign keys.right   = key_rel[KEY_RIGHT];
    assign keys.up      = key_rel[KEY_UP];
    assign keys.down    = key_rel[KEY_DOWN];
    assign keys.confirm = key_rel[KEY_CONFIRM];
    assign keys.quit    = key_rel[KEY_QUIT];
    assign keys.capture = key_rel[KEY_CAPTURE];

    mode_menu u_mode_menu (
        .clk_50M     (clk_50M),
        .rst_n       (rst_n),
        .keys        (keys.dst),
        .mode        (mode_q),
        .menu_cursor (menu_cursor)
    );

    assign mode = mode_q;

    siggen_settings u_siggen_settings (
        .clk_50M       (clk_50M),
        .rst_n         (rst_n),
        .keys          (keys.dst),
        .mode          (mode_q),
        .sg_row        (sg_row),
        .sg_wave       (sg_wave),
        .sg_amp        (sg_amp),
        .sg_freq       (sg_freq),
        .sg_phase_duty (sg_phase_duty),
        .sg_run        (sg_run)
    );

    scope_settings u_scope_settings (
        .clk_50M     (clk_50M),
        .rst_n       (rst_n),
        .keys        (keys.dst),
        .mode        (mode_q),
        .scope_fft   (scope_fft),
        .scope_vzoom (scope_vzoom),
        .scope_hzoom (scope_hzoom)
    );

    la_settings u_la_settings (
        .clk_50M      (clk_50M),
        .rst_n        (rst_n),
        .keys         (keys.dst),
        .mode         (mode_q),
        .menu_cursor  (menu_cursor),
        .la_pause     (la_pause),
        .la_pan_left  (la_pan_left),
        .la_pan_right (la_pan_right),
        .la_trig_mode (la_trig_mode),
        .la_capture   (la_capture),
        .la_marker_x  (la_marker_x),
        .la_div_sel   (la_div_sel)
    );

endmodule

// File: verif/panel_sva.sv
`timescale 1ns/100ps

module panel_sva
    import panel_pkg::*;
(
    input logic        clk_50M,
    input logic        rst_n,
    input logic [1:0]  mode,
    input logic [1:0]  menu_cursor,
    input logic        sg_run,
    input logic        la_pause,
    input logic        la_pan_left,
    input logic        la_pan_right,
    input logic [11:0] la_marker_x
);

    marker_range: assert property (@(posedge clk_50M) disable iff (!rst_n)
        la_marker_x >= MARKER_MIN && la_marker_x <= MARKER_MAX)
        else $error("la_marker_x out of range");

    marker_step: assert property (@(posedge clk_50M) disable iff (!rst_n)
        (la_marker_x % MARKER_STEP) == 12'd0)
        else $error("la_marker_x off the marker step");

    pan_while_paused: assert property (@(posedge clk_50M) disable iff (!rst_n)
        (la_pan_left || la_pan_right) |-> la_pause)
        else $error("pan pulse while not paused");

    // run clears one cycle after the generator is left
    run_in_siggen: assert property (@(posedge clk_50M) disable iff (!rst_n)
        sg_run |-> (mode == MODE_SIGGEN || $past(mode) == MODE_SIGGEN))
        else $error("sg_run set outside the signal generator");

    cursor_range: assert property (@(posedge clk_50M) disable iff (!rst_n)
        menu_cursor <= MENU_LAST)
        else $error("menu_cursor past the last entry");

endmodule

bind panel_top panel_sva u_panel_sva (
    .clk_50M      (clk_50M),
    .rst_n        (rst_n),
    .mode         (mode),
    .menu_cursor  (menu_cursor),
    .sg_run       (sg_run),
    .la_pause     (la_pause),
    .la_pan_left  (la_pan_left),
    .la_pan_right (la_pan_right),
    .la_marker_x  (la_marker_x)
);

// File: verif/tb_panel.sv
`timescale 1ns/100ps

module tb_panel
    import panel_pkg::*;
();

    localparam int HOLD_CYCLES  = DEBOUNCE_CYCLES + 20;
    localparam int PRESS_CYCLES = 2 * HOLD_CYCLES + 1;
    // about 90 directed presses, 200 random ones, and some margin
    localparam int MAX_PRESSES    = 320;
    localparam int TIMEOUT_CYCLES = MAX_PRESSES * PRESS_CYCLES + 100;
    localparam int RANDOM_PRESSES = 200;

    typedef struct packed {
        mode_e           mode;
        logic [1:0]      cursor;
        logic [2:0]      row;
        logic [3:0][1:0] field;
        logic            run;
        logic            fft;
        logic [1:0]      vzoom;
        logic [1:0]      hzoom;
        logic            pause;
        logic            trig;
        logic            capture;
        logic [11:0]     marker;
        logic [3:0]      div;
        logic            pan_l;
        logic            pan_r;
    } model_t;

    logic                clk_50M;
    logic                rst_n;
    logic [NUM_KEYS-1:0] key_in;
    logic [1:0]          mode;
    logic [1:0]          menu_cursor;
    logic [2:0]          sg_row;
    logic [1:0]          sg_wave;
    logic [1:0]          sg_amp;
    logic [1:0]          sg_freq;
    logic [1:0]          sg_phase_duty;
    logic                sg_run;
    logic                scope_fft;
    logic [1:0]          scope_vzoom;
    logic [1:0]          scope_hzoom;
    logic                la_pause;
    logic                la_pan_left;
    logic                la_pan_right;
    logic                la_trig_mode;
    logic                la_capture;
    logic [11:0]         la_marker_x;
    logic [3:0]          la_div_sel;

    model_t expected;
    int     pan_left_cnt;
    int     pan_right_cnt;
    int     pan_left_seen;
    int     pan_right_seen;
    int     cycle_cnt;
    event   check_ev;

    panel_top u_panel_top (.*);

    initial begin
        clk_50M = 1'b0;
        forever #10 clk_50M = ~clk_50M;
    end

    function automatic model_t reset_model();
        model_t m;
        m        = '0;
        m.mode   = MODE_MENU;
        m.trig   = 1'b1;
        m.marker = MARKER_MIN;
        m.div    = DIV_RESET;
        return m;
    endfunction

    // expected state after one released key
    function automatic model_t apply_key(model_t m, int k);
        model_t n;
        logic [1:0] f;
        n       = m;
        n.pan_l = 1'b0;
        n.pan_r = 1'b0;
        f       = m.field[m.row[1:0]];
        case (m.mode)
            MODE_MENU: begin
                if (k == KEY_CONFIRM) begin
                    case (m.cursor)
                        2'd0:    n.mode = MODE_SIGGEN;
                        2'd1:    n.mode = MODE_SCOPE;
                        default: n.mode = MODE_LA;
                    endcase
                end else if (k == KEY_LEFT) begin
                    n.cursor = (m.cursor == 2'd0) ? MENU_LAST : m.cursor - 2'd1;
                end else if (k == KEY_RIGHT) begin
                    n.cursor = (m.cursor == MENU_LAST) ? 2'd0 : m.cursor + 2'd1;
                end else if (k == KEY_UP && m.cursor == MENU_LAST) begin
                    n.trig = 1'b1;
                end else if (k == KEY_DOWN && m.cursor == MENU_LAST) begin
                    n.trig = 1'b0;
                end
            end
            MODE_SIGGEN: begin
                if (k == KEY_UP) begin
                    n.row = (m.row == 3'd0) ? SG_RUN_ROW : m.row - 3'd1;
                end else if (k == KEY_DOWN) begin
                    n.row = (m.row == SG_RUN_ROW) ? 3'd0 : m.row + 3'd1;
                end else if (k == KEY_LEFT && m.row < SG_RUN_ROW) begin
                    n.field[m.row[1:0]] = (f == 2'd0) ? SG_FIELD_MAX : f - 2'd1;
                end else if (k == KEY_RIGHT && m.row < SG_RUN_ROW) begin
                    n.field[m.row[1:0]] = (f == SG_FIELD_MAX) ? 2'd0 : f + 2'd1;
                end else if (k == KEY_CONFIRM && m.row == SG_RUN_ROW) begin
                    n.run = 1'b1;
                end
            end
            MODE_SCOPE: begin
                if (k == KEY_CONFIRM) begin
                    n.fft = 1'b1;
                end else if (!m.fft && k == KEY_UP) begin
                    n.vzoom = (m.vzoom == ZOOM_MAX) ? 2'd0 : m.vzoom + 2'd1;
                end else if (!m.fft && k == KEY_DOWN) begin
                    n.vzoom = (m.vzoom == 2'd0) ? ZOOM_MAX : m.vzoom - 2'd1;
                end else if (!m.fft && k == KEY_RIGHT) begin
                    n.hzoom = (m.hzoom == ZOOM_MAX) ? 2'd0 : m.hzoom + 2'd1;
                end else if (!m.fft && k == KEY_LEFT) begin
                    n.hzoom = (m.hzoom == 2'd0) ? ZOOM_MAX : m.hzoom - 2'd1;
                end
            end
            default: begin
                if (k == KEY_CONFIRM) begin
                    n.pause = ~m.pause;
                end else if (k == KEY_UP) begin
                    n.pan_l = m.pause;
                    if (!m.pause) begin
                        n.div = (m.div == DIV_MAX) ? 4'd0 : m.div + 4'd1;
                    end
                end else if (k == KEY_DOWN) begin
                    n.pan_r = m.pause;
                    if (!m.pause) begin
                        n.div = (m.div == 4'd0) ? DIV_MAX : m.div - 4'd1;
                    end
                end else if (k == KEY_LEFT) begin
                    n.marker = (m.marker == MARKER_MIN) ? MARKER_MAX : m.marker - MARKER_STEP;
                end else if (k == KEY_RIGHT) begin
                    n.marker = (m.marker == MARKER_MAX) ? MARKER_MIN : m.marker + MARKER_STEP;
                end else if (k == KEY_CAPTURE) begin
                    n.capture = 1'b1;
                end
            end
        endcase
        if (m.mode != MODE_MENU && k == KEY_QUIT) begin
            n.mode   = MODE_MENU;
            n.cursor = 2'd0;
        end
        // blocks outside their own mode sit at reset values
        if (n.mode != MODE_SIGGEN) begin
            n.row   = 3'd0;
            n.field = '0;
            n.run   = 1'b0;
        end
        if (n.mode != MODE_SCOPE) begin
            n.fft = 1'b0;
        end
        if (n.mode != MODE_SCOPE || n.fft) begin
            n.vzoom = 2'd0;
            n.hzoom = 2'd0;
        end
        if (n.mode != MODE_LA) begin
            n.pause   = 1'b0;
            n.capture = 1'b0;
            n.marker  = MARKER_MIN;
            n.div     = DIV_RESET;
            if (!(n.mode == MODE_MENU && n.cursor == MENU_LAST)) begin
                n.trig = 1'b1;
            end
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, want);
            $display("Finished with errors");
            $fatal(1, "output check failed");
        end
    endtask

    task automatic compare_outputs();
        check_value("mode", 32'(mode), 32'(expected.mode));
        check_value("menu_cursor", 32'(menu_cursor), 32'(expected.cursor));
        check_value("sg_row", 32'(sg_row), 32'(expected.row));
        check_value("sg_wave", 32'(sg_wave), 32'(expected.field[0]));
        check_value("sg_amp", 32'(sg_amp), 32'(expected.field[1]));
        check_value("sg_freq", 32'(sg_freq), 32'(expected.field[2]));
        check_value("sg_phase_duty", 32'(sg_phase_duty), 32'(expected.field[3]));
        check_value("sg_run", 32'(sg_run), 32'(expected.run));
        check_value("scope_fft", 32'(scope_fft), 32'(expected.fft));
        check_value("scope_vzoom", 32'(scope_vzoom), 32'(expected.vzoom));
        check_value("scope_hzoom", 32'(scope_hzoom), 32'(expected.hzoom));
        check_value("la_pause", 32'(la_pause), 32'(expected.pause));
        check_value("la_trig_mode", 32'(la_trig_mode), 32'(expected.trig));
        check_value("la_capture", 32'(la_capture), 32'(expected.capture));
        check_value("la_marker_x", 32'(la_marker_x), 32'(expected.marker));
        check_value("la_div_sel", 32'(la_div_sel), 32'(expected.div));
        // pulses are idle between presses, so count their cycles
        check_value("la_pan_left", 32'(la_pan_left), 32'd0);
        check_value("la_pan_right", 32'(la_pan_right), 32'd0);
        check_value("la_pan_left cycles", 32'(pan_left_seen), 32'(expected.pan_l));
        check_value("la_pan_right cycles", 32'(pan_right_seen), 32'(expected.pan_r));
    endtask

    always begin
        @(check_ev);
        compare_outputs();
    end

    always @(negedge clk_50M) begin
        if (la_pan_left) begin
            pan_left_cnt <= pan_left_cnt + 1;
        end
        if (la_pan_right) begin
            pan_right_cnt <= pan_right_cnt + 1;
        end
    end

    task automatic request_check(input int base_l, input int base_r);
        pan_left_seen  = pan_left_cnt - base_l;
        pan_right_seen = pan_right_cnt - base_r;
        -> check_ev;
    endtask

    task automatic press_key(input int k);
        int base_l;
        int base_r;
        base_l = pan_left_cnt;
        base_r = pan_right_cnt;
        @(negedge clk_50M);
        key_in[k] = 1'b1;
        repeat (HOLD_CYCLES) @(negedge clk_50M);
        key_in[k] = 1'b0;
        repeat (HOLD_CYCLES) @(negedge clk_50M);
        expected = apply_key(expected, k);
        request_check(base_l, base_r);
    endtask

    task automatic press_repeat(input int k, input int n);
        for (int i = 0; i < n; i++) begin
            press_key(k);
        end
    endtask

    // two short high bursts, neither long enough to be accepted
    task automatic glitch_key(input int k);
        int base_l;
        int base_r;
        base_l = pan_left_cnt;
        base_r = pan_right_cnt;
        @(negedge clk_50M);
        key_in[k] = 1'b1;
        repeat (DEBOUNCE_CYCLES / 2) @(negedge clk_50M);
        key_in[k] = 1'b0;
        repeat (DEBOUNCE_CYCLES / 4) @(negedge clk_50M);
        key_in[k] = 1'b1;
        repeat (DEBOUNCE_CYCLES / 2) @(negedge clk_50M);
        key_in[k] = 1'b0;
        repeat (HOLD_CYCLES) @(negedge clk_50M);
        request_check(base_l, base_r);
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_50M);
            cycle_cnt++;
        end
        $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(32'hc692fc67));
        rst_n         = 1'b0;
        key_in        = '0;
        pan_left_cnt  = 0;
        pan_right_cnt = 0;
        expected      = reset_model();
        repeat (16) @(negedge clk_50M);
        rst_n = 1'b1;
        repeat (2) @(negedge clk_50M);
        request_check(0, 0);

        // menu wrap, then each mode in and out
        press_repeat(KEY_RIGHT, 3);
        press_key(KEY_LEFT);
        press_key(KEY_RIGHT);
        for (int c = 0; c <= 2; c++) begin
            press_repeat(KEY_RIGHT, c);
            press_key(KEY_CONFIRM);
            press_key(KEY_QUIT);
        end

        // signal generator
        press_key(KEY_CONFIRM);
        press_key(KEY_UP);
        press_key(KEY_DOWN);
        for (int r = 0; r < 4; r++) begin
            press_repeat(KEY_RIGHT, 5);
            press_repeat(KEY_LEFT, 2);
            press_key(KEY_DOWN);
        end
        press_key(KEY_CONFIRM);
        press_key(KEY_QUIT);

        // oscilloscope, zooms then fft
        press_key(KEY_RIGHT);
        press_key(KEY_CONFIRM);
        press_repeat(KEY_UP, 4);
        press_repeat(KEY_DOWN, 2);
        press_repeat(KEY_RIGHT, 4);
        press_repeat(KEY_LEFT, 2);
        press_key(KEY_CONFIRM);
        press_key(KEY_UP);
        press_key(KEY_RIGHT);
        press_key(KEY_DOWN);
        press_key(KEY_LEFT);
        press_key(KEY_QUIT);

        // logic analyzer with trigger mode picked on the menu
        press_repeat(KEY_RIGHT, 2);
        press_key(KEY_DOWN);
        press_key(KEY_CONFIRM);
        press_repeat(KEY_LEFT, 2);
        press_repeat(KEY_RIGHT, 2);
        press_repeat(KEY_UP, 4);
        press_repeat(KEY_DOWN, 2);
        press_key(KEY_CONFIRM);
        press_key(KEY_UP);
        press_key(KEY_DOWN);
        press_key(KEY_CONFIRM);
        press_key(KEY_CAPTURE);
        press_key(KEY_QUIT);
        press_repeat(KEY_RIGHT, 2);
        press_key(KEY_DOWN);
        press_key(KEY_UP);

        glitch_key(KEY_CONFIRM);

        for (int i = 0; i < RANDOM_PRESSES; i++) begin
            press_key(int'($urandom % NUM_KEYS));
        end

        @(negedge clk_50M);
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: tb.f
design/panel_pkg.sv
design/panel_keys_if.sv
design/key_debounce.sv
design/mode_menu.sv
design/siggen_settings.sv
design/scope_settings.sv
design/la_settings.sv
design/panel_top.sv
verif/panel_sva.sv
verif/tb_panel.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_panel -f tb.f -o tb_panel
	./obj_dir/tb_panel

clean:
	rm -rf obj_dir
